//--- verilog/ecc_defines.svh
`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

// SECDED(116,108) code geometry
`define ECC_DATA_W      108
`define ECC_PAR_W       8

// Low check bits hold the Hamming position, the top one is overall parity
`define ECC_POS_W       (`ECC_PAR_W - 1)

// First position that no longer fits in the position field
`define ECC_POS_LIMIT   (1 << `ECC_POS_W)

// One cycle for the encode tree, one for the syndrome decode
`define ECC_LATENCY     2

`endif

//--- verilog/ecc_pkg.sv
`include "ecc_defines.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_W-1:0] ecc_data_t;
    typedef logic [`ECC_PAR_W-1:0]  ecc_par_t;     // Check bits and syndrome

    // Word entering stage 1
    typedef struct packed {
        ecc_data_t data;
        ecc_par_t  parity;      // Received check bits
        logic      bypass;
    } ecc_in_t;

    // Stage 1 to stage 2
    typedef struct packed {
        ecc_data_t data;
        ecc_par_t  parity;      // Check bits computed from data
        ecc_par_t  syndrome;
        logic      bypass;
        logic      valid;
    } ecc_syn_t;

    // Block output
    typedef struct packed {
        ecc_data_t data;        // Corrected data
        ecc_par_t  parity;
        logic      sbit_err;
        logic      dbit_err;
        logic      valid;
    } ecc_out_t;

    // Column of the parity check matrix for data bit k.
    // Data bits take the Hamming positions that are not powers of two,
    // starting at 3. Bit 7 makes every column odd weight.
    function automatic ecc_par_t ecc_column(input int unsigned k);
        int unsigned cnt;
        ecc_par_t    col;

        cnt = 0;
        col = '0;
        for (int unsigned pos = 3; pos < `ECC_POS_LIMIT; pos++) begin
            if ((pos & (pos - 1)) != 0) begin   // Skip check-bit positions
                if (cnt == k) begin
                    col[`ECC_POS_W-1:0] = pos[`ECC_POS_W-1:0];
                end
                cnt++;
            end
        end
        col[`ECC_PAR_W-1] = ~^col[`ECC_POS_W-1:0];
        return col;
    endfunction

endpackage

//--- verilog/ecc_encoder.sv
`timescale 1ns/10ps

`include "ecc_defines.svh"

module ecc_encoder (
    input  ecc_pkg::ecc_data_t data,
    output ecc_pkg::ecc_par_t  parity
);

    import ecc_pkg::*;

    // Each data bit toggles the check bits named by its column.
    // The columns fold to constants, leaving one XOR tree per check bit.
    always_comb begin
        parity = '0;
        for (int unsigned k = 0; k < `ECC_DATA_W; k++) begin
            parity = parity ^ (ecc_column(k) & {`ECC_PAR_W{data[k]}});
        end
    end

endmodule

//--- verilog/ecc_syndrome_stage.sv
`timescale 1ns/10ps

module ecc_syndrome_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  ecc_pkg::ecc_in_t in_bus,
    output ecc_pkg::ecc_syn_t syn_bus
);

    import ecc_pkg::*;

    ecc_par_t  calc_parity;
    ecc_par_t  syndrome;

    logic      valid_q;
    ecc_data_t data_q;
    ecc_par_t  parity_q;
    ecc_par_t  syndrome_q;
    logic      bypass_q;

    ecc_encoder u_encoder (
        .data   (in_bus.data),
        .parity (calc_parity)
    );

    assign syndrome = in_bus.parity ^ calc_parity;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // Payload loads every cycle, valid_q says whether it means anything
    always_ff @(posedge clk) begin
        data_q     <= in_bus.data;
        parity_q   <= calc_parity;
        syndrome_q <= syndrome;
        bypass_q   <= in_bus.bypass;
    end

    always_comb begin
        syn_bus.data     = data_q;
        syn_bus.parity   = parity_q;
        syn_bus.syndrome = syndrome_q;
        syn_bus.bypass   = bypass_q;
        syn_bus.valid    = valid_q;
    end

endmodule

//--- verilog/ecc_syndrome_decoder.sv
`timescale 1ns/10ps

`include "ecc_defines.svh"

module ecc_syndrome_decoder (
    input  ecc_pkg::ecc_par_t  syndrome,
    output ecc_pkg::ecc_data_t mask,
    output logic               sbit_err,
    output logic               dbit_err
);

    import ecc_pkg::*;

    logic data_hit;     // Syndrome names a data bit
    logic par_hit;      // Syndrome names a check bit
    logic nonzero;

    // One compare per data column, at most one can match
    always_comb begin
        mask = '0;
        for (int unsigned k = 0; k < `ECC_DATA_W; k++) begin
            if (syndrome == ecc_column(k)) begin
                mask[k] = 1'b1;
            end
        end
    end

    assign data_hit = |mask;
    assign nonzero  = |syndrome;

    // Single set bit means the check bit itself flipped
    assign par_hit = nonzero && ((syndrome & (syndrome - 1'b1)) == '0);

    // Odd-weight columns, so an even-weight syndrome is always two flips.
    // Odd weights that match no column are past correction as well.
    always_comb begin
        sbit_err = data_hit | par_hit;
        dbit_err = nonzero & ~sbit_err;
    end

endmodule

//--- verilog/ecc_correct_stage.sv
`timescale 1ns/10ps

module ecc_correct_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  ecc_pkg::ecc_syn_t syn_bus,
    output ecc_pkg::ecc_out_t out_bus
);

    import ecc_pkg::*;

    ecc_data_t mask;
    logic      sbit_dec;
    logic      dbit_dec;
    ecc_data_t data_corr;
    logic      flag_en;

    logic      valid_q;
    logic      sbit_q;
    logic      dbit_q;
    ecc_data_t data_q;
    ecc_par_t  parity_q;

    ecc_syndrome_decoder u_decoder (
        .syndrome (syn_bus.syndrome),
        .mask     (mask),
        .sbit_err (sbit_dec),
        .dbit_err (dbit_dec)
    );

    assign data_corr = syn_bus.bypass ? syn_bus.data : (syn_bus.data ^ mask);
    assign flag_en   = syn_bus.valid & ~syn_bus.bypass;   // Flags only for live, checked words

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            sbit_q  <= 1'b0;
            dbit_q  <= 1'b0;
        end else begin
            valid_q <= syn_bus.valid;
            sbit_q  <= flag_en & sbit_dec;
            dbit_q  <= flag_en & dbit_dec;
        end
    end

    always_ff @(posedge clk) begin
        data_q   <= data_corr;
        parity_q <= syn_bus.parity;
    end

    always_comb begin
        out_bus.data     = data_q;
        out_bus.parity   = parity_q;
        out_bus.sbit_err = sbit_q;
        out_bus.dbit_err = dbit_q;
        out_bus.valid    = valid_q;
    end

endmodule

//--- verilog/ecc_108_top.sv
`timescale 1ns/10ps

module ecc_108_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  ecc_pkg::ecc_in_t  in_bus,
    output ecc_pkg::ecc_out_t out_bus
);

    import ecc_pkg::*;

    ecc_syn_t syn_bus;  // Stage 1 register

    // Encode tree and compare
    ecc_syndrome_stage u_syndrome_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_bus   (in_bus),
        .syn_bus  (syn_bus)
    );

    // Syndrome decode and correction
    ecc_correct_stage u_correct_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .syn_bus  (syn_bus),
        .out_bus  (out_bus)
    );

endmodule

//--- dv/ecc_tb.sv
`timescale 1ns/10ps

`include "ecc_defines.svh"

module ecc_tb;

    import ecc_pkg::*;

    localparam int unsigned N_VEC      = 200;  // Words per phase
    localparam int unsigned N_PHASE    = 6;
    localparam int unsigned RST_CYC    = 16;
    localparam int unsigned TIMEOUT_NS = (N_VEC * N_PHASE + RST_CYC + 100) * 40;
    localparam int unsigned N_BITS     = `ECC_DATA_W + `ECC_PAR_W;  // Full code word

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_valid;
    ecc_in_t     in_bus;
    ecc_out_t    out_bus;

    logic [31:0] rng = 32'h35dd;
    int unsigned edge_cnt = 0;
    int unsigned value_errs = 0;
    int unsigned proto_errs = 0;
    ecc_par_t    col_tab [`ECC_DATA_W];
    ecc_out_t    exp_q [$];
    int unsigned due_q [$];    // Edge count at which each result must show

    ecc_108_top u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_bus   (in_bus),
        .out_bus  (out_bus)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic ecc_data_t rand_data();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r0 = rand32();
        r1 = rand32();
        r2 = rand32();
        r3 = rand32();
        return {r3[11:0], r2, r1, r0};
    endfunction

    // Check bit j covers every data bit whose column has bit j set
    function automatic ecc_par_t encode_ref(input ecc_data_t d);
        ecc_par_t p;
        p = '0;
        for (int j = 0; j < `ECC_PAR_W; j++) begin
            for (int k = 0; k < `ECC_DATA_W; k++) begin
                if (col_tab[k][j]) begin
                    p[j] = p[j] ^ d[k];
                end
            end
        end
        return p;
    endfunction

    function automatic ecc_out_t ref_model(input ecc_in_t w);
        ecc_out_t r;
        ecc_par_t syn;
        int       hit;
        r.data     = w.data;
        r.parity   = encode_ref(w.data);
        r.sbit_err = 1'b0;
        r.dbit_err = 1'b0;
        r.valid    = 1'b1;
        syn = w.parity ^ r.parity;
        hit = -1;
        for (int k = 0; k < `ECC_DATA_W; k++) begin
            if (col_tab[k] == syn) begin
                hit = k;
            end
        end
        if (!w.bypass && syn != '0) begin
            if (hit >= 0) begin
                r.data[hit] = ~r.data[hit];
                r.sbit_err  = 1'b1;
            end else if ($countones(syn) == 1) begin
                r.sbit_err = 1'b1;      // Check bit flipped
            end else begin
                r.dbit_err = 1'b1;
            end
        end
        return r;
    endfunction

    // Positions past the data bits index into the check field
    function automatic ecc_in_t flip_bit(input ecc_in_t w, input int unsigned pos);
        ecc_in_t r;
        r = w;
        if (pos < `ECC_DATA_W) begin
            r.data[pos] = ~r.data[pos];
        end else begin
            r.parity[pos - `ECC_DATA_W] = ~r.parity[pos - `ECC_DATA_W];
        end
        return r;
    endfunction

    // Kind 0 clean, 1 data flip, 2 check flip, 3 two flips
    function automatic ecc_in_t make_word(input int unsigned kind, input logic bypass);
        ecc_in_t     w;
        int unsigned a;
        int unsigned b;
        w.data   = rand_data();
        w.parity = encode_ref(w.data);
        w.bypass = bypass;
        case (kind)
            1: w = flip_bit(w, rand32() % `ECC_DATA_W);
            2: w = flip_bit(w, `ECC_DATA_W + rand32() % `ECC_PAR_W);
            3: begin
                a = rand32() % N_BITS;
                b = rand32() % (N_BITS - 1);
                if (b >= a) begin
                    b++;
                end
                w = flip_bit(w, a);
                w = flip_bit(w, b);
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic compare_data(input string name, input ecc_data_t act, input ecc_data_t want);
        if (act !== want) begin
            value_errs++;
            $display("[FAIL] %s: got %h expected %h", name, act, want);
        end
    endtask

    task automatic compare_par(input string name, input ecc_par_t act, input ecc_par_t want);
        if (act !== want) begin
            value_errs++;
            $display("[FAIL] %s: got %h expected %h", name, act, want);
        end
    endtask

    task automatic compare_flag(input string name, input logic act, input logic want);
        if (act !== want) begin
            value_errs++;
            $display("[FAIL] %s: got %h expected %h", name, act, want);
        end
    endtask

    task automatic send_word(input ecc_in_t w, input logic v);
        @(posedge clk);
        in_valid <= v;
        in_bus   <= w;
        if (v) begin
            exp_q.push_back(ref_model(w));
            due_q.push_back(edge_cnt + 1 + `ECC_LATENCY);  // Captured on the next edge
        end
    endtask

    always @(negedge clk) begin
        ecc_out_t    want;
        int unsigned due;
        if (!arst_n) begin
            compare_flag("out_bus.valid", out_bus.valid, 1'b0);
            compare_flag("out_bus.sbit_err", out_bus.sbit_err, 1'b0);
            compare_flag("out_bus.dbit_err", out_bus.dbit_err, 1'b0);
        end else if (out_bus.valid) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("output valid at edge %0d with no word in flight", edge_cnt);
            end else begin
                want = exp_q.pop_front();
                due  = due_q.pop_front();
                if (due != edge_cnt) begin
                    proto_errs++;
                    $display("result came out at edge %0d but was due at edge %0d",
                             edge_cnt, due);
                end
                compare_data("out_bus.data", out_bus.data, want.data);
                compare_par("out_bus.parity", out_bus.parity, want.parity);
                compare_flag("out_bus.sbit_err", out_bus.sbit_err, want.sbit_err);
                compare_flag("out_bus.dbit_err", out_bus.dbit_err, want.dbit_err);
            end
        end else begin
            // Idle slots carry stale payload but never raise a flag
            compare_flag("out_bus.sbit_err", out_bus.sbit_err, 1'b0);
            compare_flag("out_bus.dbit_err", out_bus.dbit_err, 1'b0);
            if (due_q.size() != 0 && due_q[0] <= edge_cnt) begin
                proto_errs++;
                $display("no output for the word due at edge %0d", due_q[0]);
                want = exp_q.pop_front();
                due  = due_q.pop_front();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        int unsigned kind;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_bus   = '0;
        for (int k = 0; k < `ECC_DATA_W; k++) begin
            col_tab[k] = ecc_column(k);
        end
        repeat (RST_CYC) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge clk);     // Output must stay idle after release

        for (kind = 0; kind < 4; kind++) begin
            for (int i = 0; i < N_VEC; i++) begin
                send_word(make_word(kind, 1'b0), 1'b1);
            end
        end
        for (int i = 0; i < N_VEC; i++) begin
            send_word(make_word(1 + rand32() % 3, 1'b1), 1'b1);
        end
        // Mixed stream with gaps, stale payload still moves while valid is low
        for (int i = 0; i < N_VEC; i++) begin
            kind = rand32() % 4;
            send_word(make_word(kind, rand32() % 8 == 0), rand32() % 4 != 0);
        end

        @(posedge clk);
        in_valid <= 1'b0;
        repeat (`ECC_LATENCY + 2) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            proto_errs += exp_q.size();
            $display("%0d expected results never came out of the DUT", exp_q.size());
        end
        $display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/ecc_pkg.sv
verilog/ecc_encoder.sv
verilog/ecc_syndrome_stage.sv
verilog/ecc_syndrome_decoder.sv
verilog/ecc_correct_stage.sv
verilog/ecc_108_top.sv
dv/ecc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f sim.f --top-module ecc_tb -o ecc_sim &&
./obj_dir/ecc_sim | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" && exit 0 ||
{ echo "simulation reported failure"; exit 1; }
